//--- Makefile
TOP = his_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing -f all.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

//--- all.f
+incdir+design
design/his_pkg.sv
design/his_acq_sequencer.sv
design/his_bin_accumulator.sv
design/his_apb_readout.sv
design/his_top.sv
test/his_clk_gen.sv
test/his_tb.sv

//--- design/his_acq_sequencer.sv
`default_nettype none

`include "his_macros.svh"

module his_acq_sequencer
    import his_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     res,
    input  wire logic     photon_valid,
    input  wire photon_t  photon,
    output logic          tag_valid,
    output tagged_photon_t tag,
    output logic          bank,
    output logic          frame_done
);

    // counter widths, one spare value keeps them at least one bit
    localparam int EVT_W = $clog2(`HIS_EVENTS_PER_PIXEL + 1);
    localparam int PIX_W = `HIS_PIX_BITS;
    localparam int ACQ_W = $clog2(`HIS_ACQ_PER_FRAME + 1);

    localparam logic [EVT_W-1:0] EVT_LAST = EVT_W'(`HIS_EVENTS_PER_PIXEL - 1);
    localparam logic [PIX_W-1:0] PIX_LAST = PIX_W'(`HIS_NUM_PIXELS - 1);
    localparam logic [ACQ_W-1:0] ACQ_LAST = ACQ_W'(`HIS_ACQ_PER_FRAME - 1);

    logic [EVT_W-1:0] evt_cnt;
    logic [PIX_W-1:0] pix_cnt;
    logic [ACQ_W-1:0] acq_cnt;
    logic             fill_bank;
    logic             evt_wrap;
    logic             pix_wrap;
    logic             acq_wrap;

    // wrap chain, inner counter first
    assign evt_wrap = (evt_cnt == EVT_LAST);
    assign pix_wrap = evt_wrap && (pix_cnt == PIX_LAST);
    assign acq_wrap = pix_wrap && (acq_cnt == ACQ_LAST);

    // nested event / pixel / acquisition counters
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            evt_cnt   <= '0;
            pix_cnt   <= '0;
            acq_cnt   <= '0;
            fill_bank <= 1'b0;
        end else if (photon_valid) begin
            evt_cnt <= evt_wrap ? '0 : evt_cnt + 1'b1;
            if (evt_wrap) begin
                pix_cnt <= pix_wrap ? '0 : pix_cnt + 1'b1;
            end
            if (pix_wrap) begin
                acq_cnt <= acq_wrap ? '0 : acq_cnt + 1'b1;
            end
            // next photon already belongs to the other bank
            if (acq_wrap) begin
                fill_bank <= ~fill_bank;
            end
        end
    end

    // tag payload, pixel and bank as seen before this photon counted
    always_ff @(posedge clk) begin
        if (photon_valid) begin
            tag.bank  <= fill_bank;
            tag.pixel <= pix_cnt;
            tag.bin   <= photon;
        end
    end

    // visible bank lags the fill bank by one cycle
    // so it flips the cycle after the last tag of a frame
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            tag_valid  <= 1'b0;
            bank       <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            tag_valid  <= photon_valid;
            bank       <= fill_bank;
            // pulse with the flip of bank
            frame_done <= fill_bank ^ bank;
        end
    end

endmodule

`default_nettype wire

//--- design/his_apb_readout.sv
`default_nettype none

`include "his_macros.svh"

module his_apb_readout
    import his_pkg::*;
(
    input  wire logic                                  clk,
    input  wire logic                                  res,
    input  wire apb_req_t                              apb_req,
    input  wire logic                                  frame_done,
    input  wire bin_count_t                            rd_data,
    output apb_rsp_t                                   apb_rsp,
    output logic                                       rd_en,
    output logic [`HIS_PIX_BITS+`HIS_BIN_BITS-1:0]      rd_addr,
    output logic                                       frame_irq
);

    localparam int AW = `HIS_PIX_BITS + `HIS_BIN_BITS;

    his_status_t status;
    logic        access;
    logic        acc_q;
    logic        is_status;
    logic        is_bin;
    logic        clr_ready;

    // access phase of the apb transfer
    assign access = apb_req.psel && apb_req.penable;

    // 0x000 status, 0x100 upward one word per bin
    assign is_status = (apb_req.paddr == 12'h000);
    assign is_bin    = (apb_req.paddr[11:8] == 4'h1) && (apb_req.paddr[1:0] == 2'b00);

    // one read-and-clear, issued in the first access cycle only
    assign rd_en   = access && !acc_q && is_bin;
    assign rd_addr = apb_req.paddr[AW+1:2];

    // host write of bit 0 at the completing cycle
    assign clr_ready = acc_q && apb_req.pwrite && is_status && apb_req.pwdata[0];

    // wait state tracker, set after the first access cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            acc_q <= 1'b0;
        end else begin
            acc_q <= access && !acc_q;
        end
    end

    // status register and irq
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            status    <= '0;
            frame_irq <= 1'b0;
        end else begin
            frame_irq <= frame_done;
            if (frame_done) begin
                // new frame beats a host clear in the same cycle
                status.frame_ready <= 1'b1;
                status.frame_count <= status.frame_count + 1'b1;
                // previous bank never acknowledged
                if (status.frame_ready) begin
                    status.overrun <= 1'b1;
                end
            end else if (clr_ready) begin
                status.frame_ready <= 1'b0;
            end
        end
    end

    // response during the second access cycle
    // rd_data is valid here, one cycle after rd_en
    always_comb begin
        apb_rsp.pready  = acc_q;
        apb_rsp.pslverr = acc_q && !is_status && !is_bin;
        apb_rsp.prdata  = '0;
        if (acc_q && is_bin) begin
            apb_rsp.prdata = 32'(rd_data);
        end else if (acc_q && is_status) begin
            apb_rsp.prdata = 32'(status);
        end
    end

endmodule

`default_nettype wire

//--- design/his_bin_accumulator.sv
`default_nettype none

`include "his_macros.svh"

module his_bin_accumulator
    import his_pkg::*;
(
    input  wire logic                                  clk,
    input  wire logic                                  res,
    input  wire logic                                  tag_valid,
    input  wire tagged_photon_t                        tag,
    input  wire logic                                  bank,
    input  wire logic                                  rd_en,
    input  wire logic [`HIS_PIX_BITS+`HIS_BIN_BITS-1:0] rd_addr,
    output bin_count_t                                 rd_data
);

    // both banks in one array, bank bit on top of the address
    localparam int DEPTH = 2 * `HIS_NUM_PIXELS * `HIS_NUM_BINS;
    localparam int WORD_W = 1 + `HIS_PIX_BITS + `HIS_BIN_BITS;
    localparam bin_count_t CNT_MAX = '1;

    bin_count_t mem [DEPTH];

    // read stage
    logic           s1_valid;
    tagged_photon_t s1_tag;
    bin_count_t     s1_old;
    logic           s1_fwd;

    // write stage
    logic           s2_valid;
    tagged_photon_t s2_tag;
    bin_count_t     s2_old;
    bin_count_t     s2_new;

    // host side word, always the bank not being filled
    logic [WORD_W-1:0] rd_word;

    assign rd_word = {~bank, rd_addr};

    // valid bits of the two stages
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= tag_valid;
            s2_valid <= s1_valid;
        end
    end

    // stage payloads
    always_ff @(posedge clk) begin
        s1_tag <= tag;
        s2_tag <= s1_tag;
        s2_old <= s1_old;
    end

    // same word hit on the previous cycle has not reached mem yet
    assign s1_fwd = s2_valid && (s2_tag == s1_tag);
    assign s1_old = s1_fwd ? s2_new : mem[s1_tag];

    // saturating increment
    assign s2_new = (s2_old == CNT_MAX) ? s2_old : s2_old + 1'b1;

    // write port for the pipeline and read-and-clear for the host
    // clear is the later write, so it wins on a collision
    always_ff @(posedge clk) begin
        if (s2_valid) begin
            mem[s2_tag] <= s2_new;
        end
        if (rd_en) begin
            // late photon of the old bank still in the write stage
            if (s2_valid && (s2_tag == rd_word)) begin
                rd_data <= s2_new;
            end else begin
                rd_data <= mem[rd_word];
            end
            mem[rd_word] <= '0;
        end
    end

endmodule

`default_nettype wire

//--- design/his_macros.svh
`ifndef HIS_MACROS_SVH
`define HIS_MACROS_SVH

// time bins per pixel, one per tdc code
`define HIS_NUM_BINS 16
`define HIS_BIN_BITS 4

// pixels per frame
`define HIS_NUM_PIXELS 4
`define HIS_PIX_BITS 2

// events taken per pixel before moving on
`define HIS_EVENTS_PER_PIXEL 3

// acquisitions per frame, so 24 events per frame
`define HIS_ACQ_PER_FRAME 2

// bin counter width, saturates at all ones
`define HIS_COUNT_BITS 8

`endif

//--- design/his_pkg.sv
`default_nettype none

`include "his_macros.svh"

package his_pkg;

    // raw tdc output, one bin index per photon
    typedef logic [`HIS_BIN_BITS-1:0] photon_t;

    // single histogram bin counter
    typedef logic [`HIS_COUNT_BITS-1:0] bin_count_t;

    // photon placed in a frame, also the memory word address
    typedef struct packed {
        logic                     bank;
        logic [`HIS_PIX_BITS-1:0] pixel;
        photon_t                  bin;
    } tagged_photon_t;

    // apb host side
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    // status word, frame_ready lands on bit 0
    typedef struct packed {
        logic [7:0] frame_count;
        logic       overrun;
        logic       frame_ready;
    } his_status_t;

endpackage

`default_nettype wire

//--- design/his_top.sv
`default_nettype none

`include "his_macros.svh"

module his_top
    import his_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     res,
    input  wire logic     photon_valid,
    input  wire photon_t  photon,
    input  wire apb_req_t apb_req,
    output apb_rsp_t      apb_rsp,
    output logic          frame_irq
);

    // sequencer to accumulator
    logic           tag_valid;
    tagged_photon_t tag;
    logic           bank;

    // sequencer to readout
    logic frame_done;

    // readout to accumulator, bin read-and-clear
    logic                                  rd_en;
    logic [`HIS_PIX_BITS+`HIS_BIN_BITS-1:0] rd_addr;
    bin_count_t                            rd_data;

    // tags photons with pixel and bank, swaps banks per frame
    his_acq_sequencer u_seq (
        .clk          (clk),
        .res          (res),
        .photon_valid (photon_valid),
        .photon       (photon),
        .tag_valid    (tag_valid),
        .tag          (tag),
        .bank         (bank),
        .frame_done   (frame_done)
    );

    // two bank histogram memory
    his_bin_accumulator u_acc (
        .clk       (clk),
        .res       (res),
        .tag_valid (tag_valid),
        .tag       (tag),
        .bank      (bank),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    // host access and status
    his_apb_readout u_apb (
        .clk        (clk),
        .res        (res),
        .apb_req    (apb_req),
        .frame_done (frame_done),
        .rd_data    (rd_data),
        .apb_rsp    (apb_rsp),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .frame_irq  (frame_irq)
    );

endmodule

`default_nettype wire

//--- test/his_clk_gen.sv
`default_nettype none

module his_clk_gen (
    output logic clk,
    output logic res
);

    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held over two rising edges
    initial begin
        res = 1'b0;
        repeat (2) @(posedge clk);
        res <= 1'b1;
    end

endmodule

`default_nettype wire

//--- test/his_tb.sv
`default_nettype none

`include "his_macros.svh"

module his_tb
    import his_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WORDS = `HIS_NUM_PIXELS * `HIS_NUM_BINS;
    localparam int FRAME = `HIS_EVENTS_PER_PIXEL * `HIS_NUM_PIXELS * `HIS_ACQ_PER_FRAME;
    // frames to push one bin past full in both banks
    localparam int SAT_FRAMES =
        2 * ((1 << `HIS_COUNT_BITS) / (`HIS_EVENTS_PER_PIXEL * `HIS_ACQ_PER_FRAME) + 1);

    logic        clk;
    logic        res;
    logic        photon_valid;
    photon_t     photon;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        frame_irq;
    logic [15:0] lfsr;
    int          errors;
    int          timeouts;

    // model of the frame counting and of both banks
    int          m_evt;
    int          m_pix;
    int          m_acq;
    logic        m_bank;
    bin_count_t  m_mem [2][WORDS];
    his_status_t m_status;

    his_clk_gen u_clk (.clk(clk), .res(res));

    his_top DUT (
        .clk          (clk),
        .res          (res),
        .photon_valid (photon_valid),
        .photon       (photon),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .frame_irq    (frame_irq)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic end_run();
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic check_bin(input int addr, input bin_count_t got, input bin_count_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: bin word %0d read %0d, expected %0d", $time, addr, got, exp);
        end
    endtask

    task automatic check_status(input his_status_t got, input his_status_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: status %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_rsp(input apb_rsp_t got, input apb_rsp_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s gave pslverr %b prdata %h, expected %b %h",
                     $time, what, got.pslverr, got.prdata, exp.pslverr, exp.prdata);
        end
    endtask

    task automatic check_irq(input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: frame_irq %b, expected %b", $time, got, exp);
        end
    endtask

    // events per pixel, pixels per acquisition, acquisitions per frame
    task automatic model_photon(input photon_t bin);
        int idx;
        idx = m_pix * `HIS_NUM_BINS + int'(bin);
        if (m_mem[m_bank][idx] != '1) begin
            m_mem[m_bank][idx] = m_mem[m_bank][idx] + 8'd1;
        end
        m_evt++;
        if (m_evt == `HIS_EVENTS_PER_PIXEL) begin
            m_evt = 0;
            m_pix++;
        end
        if (m_pix == `HIS_NUM_PIXELS) begin
            m_pix = 0;
            m_acq++;
        end
        // swap banks and update status at the frame end
        if (m_acq == `HIS_ACQ_PER_FRAME) begin
            m_acq = 0;
            m_bank = ~m_bank;
            if (m_status.frame_ready) begin
                m_status.overrun = 1'b1;
            end
            m_status.frame_ready = 1'b1;
            m_status.frame_count = m_status.frame_count + 8'd1;
        end
    endtask

    // n photons, optional random gaps, random or fixed bin
    task automatic send_photons(input int n, input bit gaps, input bit fixed, input photon_t fbin);
        logic [15:0] r;
        photon_t     pb;
        int          sent;
        sent = 0;
        while (sent < n) begin
            @(posedge clk);
            r = 16'h1;
            if (gaps) begin
                take_bits(1, r);
            end
            if (!r[0]) begin
                photon_valid <= 1'b0;
            end else begin
                pb = fbin;
                if (!fixed) begin
                    take_bits(`HIS_BIN_BITS, r);
                    pb = r[`HIS_BIN_BITS-1:0];
                end
                photon_valid <= 1'b1;
                photon       <= pb;
                model_photon(pb);
                sent++;
            end
        end
        @(posedge clk);
        photon_valid <= 1'b0;
    endtask

    // setup cycle, then access cycles until pready
    task automatic apb_xfer(input logic [11:0] addr, input logic wr, input logic [31:0] wdata,
                            output apb_rsp_t rsp);
        int n;
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= wr;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        n = 0;
        rsp = '0;
        while (!rsp.pready && n < 20) begin
            @(negedge clk);
            rsp = apb_rsp;
            n++;
        end
        if (!rsp.pready) begin
            $display("timeout: no pready within 20 cycles at address %h", addr);
            timeouts++;
            end_run();
        end
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    // read and clear one bin of the bank not being filled
    task automatic read_bin(input int addr, input bin_count_t exp, input bit check);
        apb_rsp_t rsp;
        apb_xfer(12'h100 + 12'(addr * 4), 1'b0, '0, rsp);
        if (check) begin
            check_bin(addr, rsp.prdata[`HIS_COUNT_BITS-1:0], exp);
        end
        m_mem[~m_bank][addr] = '0;
    endtask

    task automatic read_bank(input logic [`HIS_NUM_PIXELS-1:0] pix_mask, input bit check);
        for (int a = 0; a < WORDS; a++) begin
            if (pix_mask[a / `HIS_NUM_BINS]) begin
                read_bin(a, m_mem[~m_bank][a], check);
            end
        end
    endtask

    task automatic read_status();
        apb_rsp_t rsp;
        apb_xfer(12'h000, 1'b0, '0, rsp);
        check_status(his_status_t'(rsp.prdata[$bits(his_status_t)-1:0]), m_status);
    endtask

    // bit 0 write drops frame_ready but keeps overrun
    task automatic ack_frame();
        apb_rsp_t rsp;
        apb_xfer(12'h000, 1'b1, 32'h1, rsp);
        m_status.frame_ready = 1'b0;
        read_status();
    endtask

    task automatic wait_frame_irq();
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < 500) begin
            @(negedge clk);
            seen = frame_irq;
            n++;
        end
        if (!seen) begin
            $display("timeout: frame_irq did not pulse within 500 cycles");
            timeouts++;
            end_run();
        end else begin
            // pulse lasts a single cycle
            @(negedge clk);
            check_irq(frame_irq, 1'b0);
        end
    endtask

    initial begin
        int       n;
        apb_rsp_t rsp;
        apb_rsp_t exp_rsp;
        photon_valid = 1'b0;
        photon       = '0;
        apb_req      = '0;
        lfsr         = 16'd50;
        errors       = 0;
        timeouts     = 0;
        m_evt        = 0;
        m_pix        = 0;
        m_acq        = 0;
        m_bank       = 1'b0;
        m_status     = '0;
        n = 0;
        while (!res && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (!res) begin
            $display("timeout: reset never released");
            timeouts++;
            end_run();
        end

        // memory powers up unknown so each bank is flushed by one frame
        repeat (2) begin
            send_photons(FRAME, 1'b1, 1'b0, '0);
            wait_frame_irq();
            read_bank('1, 1'b0);
            ack_frame();
        end
        foreach (m_mem[b, a]) begin
            m_mem[b][a] = '0;
        end

        // random frames with pixel 3 skipped once so it accumulates
        for (int f = 0; f < 4; f++) begin
            send_photons(FRAME, 1'b1, 1'b0, '0);
            wait_frame_irq();
            read_status();
            read_bank((f == 0) ? 4'b0111 : 4'b1111, 1'b1);
            ack_frame();
        end

        // same bin every cycle gives three back-to-back hits per pixel
        send_photons(FRAME, 1'b0, 1'b1, 4'd5);
        wait_frame_irq();
        read_status();
        read_bin(5, bin_count_t'(`HIS_EVENTS_PER_PIXEL * `HIS_ACQ_PER_FRAME), 1'b1);
        // a second read finds the bin cleared
        read_bin(5, '0, 1'b1);
        read_bank(4'b1111, 1'b1);
        ack_frame();

        // unread frames pile onto one bin while frame_ready stays set
        send_photons(SAT_FRAMES * FRAME, 1'b0, 1'b1, 4'd9);
        wait_frame_irq();
        read_status();
        read_bin(2 * `HIS_NUM_BINS + 9, '1, 1'b1);
        read_bank(4'b1111, 1'b1);
        ack_frame();

        // undefined addresses
        exp_rsp.pready  = 1'b1;
        exp_rsp.prdata  = '0;
        exp_rsp.pslverr = 1'b1;
        apb_xfer(12'h004, 1'b0, '0, rsp);
        check_rsp(rsp, exp_rsp, "read of 0x004");
        apb_xfer(12'h102, 1'b0, '0, rsp);
        check_rsp(rsp, exp_rsp, "unaligned read of 0x102");
        apb_xfer(12'h200, 1'b1, 32'hffff_ffff, rsp);
        check_rsp(rsp, exp_rsp, "write to 0x200");
        exp_rsp.pslverr = 1'b0;
        exp_rsp.prdata  = 32'(m_status);
        apb_xfer(12'h000, 1'b0, '0, rsp);
        check_rsp(rsp, exp_rsp, "status read");
        end_run();
    end

endmodule

`default_nettype wire
